// ==== src/usb_neg_consts.svh ====
// cycle counts are scaled down for simulation; the filter length must stay below the reset length
`ifndef USB_NEG_CONSTS_SVH
`define USB_NEG_CONSTS_SVH

// a line state must hold this many cycles before it counts
`define USB_NEG_FILTER_CYCLES 4

// qualified SE0 this long is a bus reset
`define USB_NEG_RESET_CYCLES 16

// length of the device K chirp
`define USB_NEG_CHIRP_K_CYCLES 40

// detect window, counted from line release
`define USB_NEG_HS_TIMEOUT 120

// host K-J pairs needed for high speed
`define USB_NEG_MIN_PAIRS 3

`endif

// ==== src/usb_neg_pkg.sv ====
// shared types only; the low-speed code is defined but never selected by the negotiation
`default_nettype none

package usb_neg_pkg;

    typedef enum logic [1:0] {
        speed_full = 2'b00,
        speed_high = 2'b01,
        speed_low  = 2'b10
    } speed_e;

    // coded as {dp, dm}
    typedef enum logic [1:0] {
        line_se0 = 2'b00,
        line_k   = 2'b01,
        line_j   = 2'b10,
        line_se1 = 2'b11
    } line_e;

    typedef enum logic [2:0] {
        neg_idle             = 3'd0,
        neg_bus_reset        = 3'd1,
        neg_chirp_k          = 3'd2,
        neg_detect_handshake = 3'd3,
        neg_speed_selected   = 3'd4
    } neg_state_e;

    typedef enum logic [1:0] {
        drive_j       = 2'd0,
        drive_k       = 2'd1,
        drive_se0     = 2'd2,
        drive_release = 2'd3
    } drive_e;

endpackage

`default_nettype wire

// ==== src/usb_line_state_decode.sv ====
// dp_in/dm_in are asynchronous; chirps fire once per filtered run, bus_reset drops as SE0 leaves the synchronizer
`timescale 1ns/1ps
`default_nettype none
`include "usb_neg_consts.svh"

module usb_line_state_decode (
    input  logic clk,
    input  logic rst_n,
    input  logic dp_in,
    input  logic dm_in,
    output logic bus_reset,
    output logic chirp_k,
    output logic chirp_j
);

    localparam int run_w = $clog2(`USB_NEG_RESET_CYCLES + 1);
    localparam logic [run_w-1:0] run_max = run_w'(`USB_NEG_RESET_CYCLES);
    localparam logic [run_w-1:0] filter_last = run_w'(`USB_NEG_FILTER_CYCLES - 1);
    localparam logic [run_w-1:0] reset_last = run_w'(`USB_NEG_RESET_CYCLES - 1);

    logic dp_meta;
    logic dm_meta;
    logic dp_sync;
    logic dm_sync;
    usb_neg_pkg::line_e line_now;
    usb_neg_pkg::line_e line_q;
    usb_neg_pkg::line_e line_filt;
    logic [run_w-1:0] run_cnt;
    logic held;
    logic qualify;
    logic reset_hold;

    assign line_now = usb_neg_pkg::line_e'({dp_sync, dm_sync});
    assign held = (line_now == line_q);
    assign qualify = held && (run_cnt == filter_last);
    assign bus_reset = reset_hold && (line_now == usb_neg_pkg::line_se0);

    // synchronizer parks at J idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_meta <= 1'b1;
            dm_meta <= 1'b0;
            dp_sync <= 1'b1;
            dm_sync <= 1'b0;
        end else begin
            dp_meta <= dp_in;
            dm_meta <= dm_in;
            dp_sync <= dp_meta;
            dm_sync <= dm_meta;
        end
    end

    // length of the current run, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_q  <= usb_neg_pkg::line_j;
            run_cnt <= '0;
        end else if (!held) begin
            line_q  <= line_now;
            run_cnt <= run_w'(1);
        end else if (run_cnt != run_max) begin
            run_cnt <= run_cnt + run_w'(1);
        end
    end

    // only a change of the filtered state produces a chirp
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_filt  <= usb_neg_pkg::line_j;
            chirp_k    <= 1'b0;
            chirp_j    <= 1'b0;
            reset_hold <= 1'b0;
        end else begin
            chirp_k <= qualify && (line_now == usb_neg_pkg::line_k)
                       && (line_filt != usb_neg_pkg::line_k);
            chirp_j <= qualify && (line_now == usb_neg_pkg::line_j)
                       && (line_filt != usb_neg_pkg::line_j);
            if (qualify) begin
                line_filt <= line_now;
            end
            if (line_now != usb_neg_pkg::line_se0) begin
                reset_hold <= 1'b0;
            end else if (held && (run_cnt == reset_last)) begin
                reset_hold <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/usb_speed_negotiation.sv ====
// a bus reset restarts negotiation from any state; a pair that closes on the timeout cycle still counts
`timescale 1ns/1ps
`default_nettype none
`include "usb_neg_consts.svh"

module usb_speed_negotiation (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                bus_reset,
    input  logic                chirp_k,
    input  logic                chirp_j,
    input  logic                high_speed_supported,
    input  logic                negotiation_enable,
    output usb_neg_pkg::drive_e drive,
    output usb_neg_pkg::speed_e new_speed,
    output logic                speed_valid,
    output logic                neg_clear
);

    localparam int timer_w = $clog2(`USB_NEG_CHIRP_K_CYCLES + `USB_NEG_HS_TIMEOUT);
    localparam logic [timer_w-1:0] chirp_last = timer_w'(`USB_NEG_CHIRP_K_CYCLES - 1);
    localparam logic [timer_w-1:0] window_last = timer_w'(`USB_NEG_HS_TIMEOUT - 1);
    localparam logic [3:0] pair_max = 4'd15;
    localparam logic [3:0] pair_min = 4'(`USB_NEG_MIN_PAIRS);

    usb_neg_pkg::neg_state_e state;
    logic [timer_w-1:0] timer;
    logic [3:0] pairs;
    logic [3:0] pairs_next;
    logic armed;
    logic pair_hit;
    logic hs_allowed;

    assign hs_allowed = high_speed_supported && negotiation_enable;
    assign pair_hit = (state == usb_neg_pkg::neg_detect_handshake) && chirp_j && armed;
    assign pairs_next = (pair_hit && (pairs != pair_max)) ? pairs + 4'd1 : pairs;

    // high speed idles at SE0, full speed at J
    always_comb begin
        case (state)
            usb_neg_pkg::neg_chirp_k:          drive = usb_neg_pkg::drive_k;
            usb_neg_pkg::neg_detect_handshake: drive = usb_neg_pkg::drive_release;
            usb_neg_pkg::neg_speed_selected: begin
                if (new_speed == usb_neg_pkg::speed_high) begin
                    drive = usb_neg_pkg::drive_se0;
                end else begin
                    drive = usb_neg_pkg::drive_j;
                end
            end
            default:                           drive = usb_neg_pkg::drive_j;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= usb_neg_pkg::neg_idle;
            timer       <= '0;
            new_speed   <= usb_neg_pkg::speed_full;
            speed_valid <= 1'b0;
            neg_clear   <= 1'b0;
        end else begin
            speed_valid <= 1'b0;
            neg_clear   <= 1'b0;
            if (bus_reset && (state != usb_neg_pkg::neg_bus_reset)) begin
                state     <= usb_neg_pkg::neg_bus_reset;
                neg_clear <= 1'b1;
            end else begin
                case (state)
                    usb_neg_pkg::neg_bus_reset: begin
                        if (!bus_reset && hs_allowed) begin
                            state <= usb_neg_pkg::neg_chirp_k;
                            timer <= '0;
                        end else if (!bus_reset) begin
                            state       <= usb_neg_pkg::neg_speed_selected;
                            new_speed   <= usb_neg_pkg::speed_full;
                            speed_valid <= 1'b1;
                        end
                    end
                    usb_neg_pkg::neg_chirp_k: begin
                        if (timer == chirp_last) begin
                            state <= usb_neg_pkg::neg_detect_handshake;
                            timer <= '0;
                        end else begin
                            timer <= timer + timer_w'(1);
                        end
                    end
                    usb_neg_pkg::neg_detect_handshake: begin
                        if (timer == window_last) begin
                            state       <= usb_neg_pkg::neg_speed_selected;
                            speed_valid <= 1'b1;
                            new_speed   <= (pairs_next >= pair_min) ?
                                           usb_neg_pkg::speed_high : usb_neg_pkg::speed_full;
                        end else begin
                            timer <= timer + timer_w'(1);
                        end
                    end
                    usb_neg_pkg::neg_speed_selected: begin
                        state <= usb_neg_pkg::neg_speed_selected;
                    end
                    default: begin
                        state <= usb_neg_pkg::neg_idle;
                    end
                endcase
            end
        end
    end

    // K arms, the following J completes a pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pairs <= 4'd0;
            armed <= 1'b0;
        end else if (state == usb_neg_pkg::neg_chirp_k) begin
            pairs <= 4'd0;
            armed <= 1'b0;
        end else if (state == usb_neg_pkg::neg_detect_handshake) begin
            pairs <= pairs_next;
            if (chirp_k) begin
                armed <= 1'b1;
            end else if (chirp_j) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/usb_line_driver.sv ====
// outputs follow their commands by one cycle; release keeps the last pin levels with both enables off
`timescale 1ns/1ps
`default_nettype none

module usb_line_driver (
    input  logic                clk,
    input  logic                rst_n,
    input  usb_neg_pkg::drive_e drive,
    input  usb_neg_pkg::speed_e new_speed,
    input  logic                speed_valid,
    input  logic                neg_clear,
    output logic                dp_out,
    output logic                dm_out,
    output logic                dp_oe,
    output logic                dm_oe,
    output usb_neg_pkg::speed_e device_speed,
    output logic                negotiation_complete,
    output logic                speed_changed
);

    // out of reset the device shows J
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_out <= 1'b1;
            dm_out <= 1'b0;
            dp_oe  <= 1'b1;
            dm_oe  <= 1'b1;
        end else begin
            case (drive)
                usb_neg_pkg::drive_j: begin
                    dp_out <= 1'b1;
                    dm_out <= 1'b0;
                    dp_oe  <= 1'b1;
                    dm_oe  <= 1'b1;
                end
                usb_neg_pkg::drive_k: begin
                    dp_out <= 1'b0;
                    dm_out <= 1'b1;
                    dp_oe  <= 1'b1;
                    dm_oe  <= 1'b1;
                end
                usb_neg_pkg::drive_se0: begin
                    dp_out <= 1'b0;
                    dm_out <= 1'b0;
                    dp_oe  <= 1'b1;
                    dm_oe  <= 1'b1;
                end
                default: begin
                    dp_oe <= 1'b0;
                    dm_oe <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            device_speed         <= usb_neg_pkg::speed_full;
            negotiation_complete <= 1'b0;
            speed_changed        <= 1'b0;
        end else begin
            speed_changed <= speed_valid && (new_speed != device_speed);
            if (speed_valid) begin
                device_speed <= new_speed;
            end
            // clear wins over a same-cycle load
            if (neg_clear) begin
                negotiation_complete <= 1'b0;
            end else if (speed_valid) begin
                negotiation_complete <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/usb_hs_negotiator.sv ====
// dp_in/dm_in are the receiver's view of the bus; the two control inputs are expected to stay static
`timescale 1ns/1ps
`default_nettype none

module usb_hs_negotiator (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dp_in,
    input  logic                dm_in,
    input  logic                high_speed_supported,
    input  logic                negotiation_enable,
    output logic                dp_out,
    output logic                dm_out,
    output logic                dp_oe,
    output logic                dm_oe,
    output usb_neg_pkg::speed_e device_speed,
    output logic                negotiation_complete,
    output logic                speed_changed
);

    logic                bus_reset;
    logic                chirp_k;
    logic                chirp_j;
    usb_neg_pkg::drive_e drive;
    usb_neg_pkg::speed_e new_speed;
    logic                speed_valid;
    logic                neg_clear;

    usb_line_state_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .dp_in     (dp_in),
        .dm_in     (dm_in),
        .bus_reset (bus_reset),
        .chirp_k   (chirp_k),
        .chirp_j   (chirp_j)
    );

    usb_speed_negotiation u_negotiation (
        .clk                  (clk),
        .rst_n                (rst_n),
        .bus_reset            (bus_reset),
        .chirp_k              (chirp_k),
        .chirp_j              (chirp_j),
        .high_speed_supported (high_speed_supported),
        .negotiation_enable   (negotiation_enable),
        .drive                (drive),
        .new_speed            (new_speed),
        .speed_valid          (speed_valid),
        .neg_clear            (neg_clear)
    );

    usb_line_driver u_driver (
        .clk                  (clk),
        .rst_n                (rst_n),
        .drive                (drive),
        .new_speed            (new_speed),
        .speed_valid          (speed_valid),
        .neg_clear            (neg_clear),
        .dp_out               (dp_out),
        .dm_out               (dm_out),
        .dp_oe                (dp_oe),
        .dm_oe                (dm_oe),
        .device_speed         (device_speed),
        .negotiation_complete (negotiation_complete),
        .speed_changed        (speed_changed)
    );

endmodule

`default_nettype wire

// ==== tests/usb_neg_assert.sv ====
// watches the line driver outputs only; the decode and negotiation stages are not observed here
`timescale 1ns/1ps
`default_nettype none

module usb_neg_assert (
    input logic                clk,
    input logic                rst_n,
    input usb_neg_pkg::drive_e drive,
    input logic                dp_oe,
    input logic                dm_oe,
    input logic                negotiation_complete,
    input logic                speed_changed
);

    // completion only comes with a driven line
    complete_not_released: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(negotiation_complete) |-> (drive != usb_neg_pkg::drive_release)
    ) else $error("negotiation_complete rose while the line was released");

    speed_changed_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        speed_changed |=> !speed_changed
    ) else $error("speed_changed held for two cycles");

    // both drop one cycle after a release command
    enables_fall_together: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($fell(dp_oe) || $fell(dm_oe)) |->
            (!dp_oe && !dm_oe && ($past(drive) == usb_neg_pkg::drive_release))
    ) else $error("dp_oe and dm_oe did not fall together after a release");

endmodule

bind usb_line_driver usb_neg_assert u_assert (
    .clk                  (clk),
    .rst_n                (rst_n),
    .drive                (drive),
    .dp_oe                (dp_oe),
    .dm_oe                (dm_oe),
    .negotiation_complete (negotiation_complete),
    .speed_changed        (speed_changed)
);

`default_nettype wire

// ==== tests/usb_neg_checker.sv ====
// samples on the falling clock edge; exp_speed must be set before the bus reset of each scenario
`timescale 1ns/1ps
`default_nettype none
`include "usb_neg_consts.svh"

module usb_neg_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dp_in,
    input  logic                dm_in,
    input  logic                dp_out,
    input  logic                dm_out,
    input  logic                dp_oe,
    input  logic                dm_oe,
    input  usb_neg_pkg::speed_e device_speed,
    input  logic                negotiation_complete,
    input  logic                speed_changed,
    input  usb_neg_pkg::speed_e exp_speed,
    input  logic                k_forbidden,
    output int                  value_errors,
    output int                  rule_errors
);

    int value_count = 0;
    int rule_count = 0;
    int se0_run;
    int k_run;
    logic complete_q;
    logic is_k;
    usb_neg_pkg::speed_e model_speed;

    assign value_errors = value_count;
    assign rule_errors = rule_count;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            value_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic rule_broken(input string what);
        rule_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            compare("dp_out", 32'(dp_out), 32'd1);
            compare("dm_out", 32'(dm_out), 32'd0);
            compare("dp_oe", 32'(dp_oe), 32'd1);
            compare("dm_oe", 32'(dm_oe), 32'd1);
            compare("negotiation_complete", 32'(negotiation_complete), 32'd0);
            compare("speed_changed", 32'(speed_changed), 32'd0);
            compare("device_speed", 32'(device_speed), 32'(usb_neg_pkg::speed_full));
            model_speed = usb_neg_pkg::speed_full;
            complete_q = 1'b0;
            se0_run = 0;
            k_run = 0;
        end else begin
            is_k = dp_oe && dm_oe && !dp_out && dm_out;
            // SE0 as the host drives it, before the synchronizer
            if (!dp_in && !dm_in) begin
                se0_run++;
            end else begin
                se0_run = 0;
            end
            // first count lands half a cycle late, then 2 sync flops, reset filter, two to clear
            if (negotiation_complete && (se0_run > `USB_NEG_RESET_CYCLES + 4)) begin
                rule_broken("negotiation_complete stayed high through a bus reset");
            end
            if (!negotiation_complete && complete_q && (se0_run < `USB_NEG_RESET_CYCLES)) begin
                rule_broken("negotiation_complete dropped without a bus reset");
            end
            if (k_forbidden && is_k) begin
                rule_broken("K driven on the pins while high speed is not allowed");
            end
            if (is_k) begin
                k_run++;
            end else if (k_run != 0) begin
                compare("k_chirp_cycles", 32'(k_run), 32'(`USB_NEG_CHIRP_K_CYCLES));
                k_run = 0;
            end
            if (negotiation_complete && !complete_q) begin
                compare("device_speed", 32'(device_speed), 32'(exp_speed));
                compare("speed_changed", 32'(speed_changed), 32'(exp_speed != model_speed));
                // high speed idles at SE0, full speed at J
                compare("dp_out", 32'(dp_out), 32'(exp_speed != usb_neg_pkg::speed_high));
                compare("dm_out", 32'(dm_out), 32'd0);
                compare("dp_oe", 32'(dp_oe), 32'd1);
                compare("dm_oe", 32'(dm_oe), 32'd1);
                model_speed = exp_speed;
            end else if (speed_changed) begin
                rule_broken("speed_changed pulsed outside a completion");
            end
            complete_q = negotiation_complete;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_usb_hs_negotiator.sv ====
// host side only; stimulus comes from a fixed xorshift seed and every wait has its own cycle limit
`timescale 1ns/1ps
`default_nettype none
`include "usb_neg_consts.svh"

module tb_usb_hs_negotiator;

    localparam int wait_k = 0;
    localparam int wait_release = 1;
    localparam int wait_done = 2;
    localparam int scenarios = 8;

    logic clk;
    logic rst_n;
    logic dp_in;
    logic dm_in;
    logic high_speed_supported;
    logic negotiation_enable;
    logic dp_out;
    logic dm_out;
    logic dp_oe;
    logic dm_oe;
    usb_neg_pkg::speed_e device_speed;
    logic negotiation_complete;
    logic speed_changed;
    usb_neg_pkg::speed_e exp_speed;
    logic k_forbidden;
    int value_errors;
    int rule_errors;
    int timeouts;
    logic [31:0] rng;
    int kinds [scenarios];

    usb_hs_negotiator DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .dp_in                (dp_in),
        .dm_in                (dm_in),
        .high_speed_supported (high_speed_supported),
        .negotiation_enable   (negotiation_enable),
        .dp_out               (dp_out),
        .dm_out               (dm_out),
        .dp_oe                (dp_oe),
        .dm_oe                (dm_oe),
        .device_speed         (device_speed),
        .negotiation_complete (negotiation_complete),
        .speed_changed        (speed_changed)
    );

    usb_neg_checker u_checker (
        .clk                  (clk),
        .rst_n                (rst_n),
        .dp_in                (dp_in),
        .dm_in                (dm_in),
        .dp_out               (dp_out),
        .dm_out               (dm_out),
        .dp_oe                (dp_oe),
        .dm_oe                (dm_oe),
        .device_speed         (device_speed),
        .negotiation_complete (negotiation_complete),
        .speed_changed        (speed_changed),
        .exp_speed            (exp_speed),
        .k_forbidden          (k_forbidden),
        .value_errors         (value_errors),
        .rule_errors          (rule_errors)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic roll(input int unsigned span, output int value);
        rng = xorshift32(rng);
        value = int'(rng % span);
    endtask

    // called at posedge+1, returns at posedge+1
    task automatic hold_line(input usb_neg_pkg::line_e state, input int cycles);
        {dp_in, dm_in} = state;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic condition_met(input int what);
        case (what)
            wait_k:       return dp_oe && dm_oe && !dp_out && dm_out;
            wait_release: return !dp_oe && !dm_oe;
            default:      return negotiation_complete;
        endcase
    endfunction

    task automatic wait_until(input int what, input int limit);
        int n;
        n = 0;
        while (!condition_met(what) && (n < limit)) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!condition_met(what)) begin
            timeouts++;
            $display("timeout at %0t: no %s within %0d cycles", $time,
                     (what == wait_k) ? "K chirp" :
                     (what == wait_release) ? "line release" : "completion", limit);
        end
    endtask

    // kind 0 full speed only, 1 host chirps, 2 host chirps with glitches
    task automatic run_scenario(input int kind);
        int pairs;
        int len;
        int i;
        pairs = 0;
        if (kind == 0) begin
            roll(3, len);
            high_speed_supported = (len == 1);
            negotiation_enable = (len == 2);
        end else begin
            high_speed_supported = 1'b1;
            negotiation_enable = 1'b1;
            roll(6, pairs);
        end
        exp_speed = (pairs >= `USB_NEG_MIN_PAIRS) ? usb_neg_pkg::speed_high
                                                  : usb_neg_pkg::speed_full;
        k_forbidden = (kind == 0);
        if (kind == 2) begin
            roll(8, len);
            hold_line(usb_neg_pkg::line_se0, `USB_NEG_FILTER_CYCLES + 1 + len);
            hold_line(usb_neg_pkg::line_j, `USB_NEG_FILTER_CYCLES + 2);
        end
        hold_line(usb_neg_pkg::line_se0, `USB_NEG_RESET_CYCLES + 8);
        hold_line(usb_neg_pkg::line_j, 1);
        if (kind == 0) begin
            wait_until(wait_done, 20);
        end else begin
            wait_until(wait_k, 20);
            wait_until(wait_release, `USB_NEG_CHIRP_K_CYCLES + 20);
            if (kind == 2) begin
                roll(`USB_NEG_FILTER_CYCLES - 1, len);
                hold_line(usb_neg_pkg::line_k, 1 + len);
                hold_line(usb_neg_pkg::line_j, `USB_NEG_FILTER_CYCLES + 1);
                roll(`USB_NEG_FILTER_CYCLES - 1, len);
                hold_line(usb_neg_pkg::line_se0, 1 + len);
                hold_line(usb_neg_pkg::line_j, `USB_NEG_FILTER_CYCLES + 1);
            end
            for (i = 0; i < pairs; i++) begin
                roll(4, len);
                hold_line(usb_neg_pkg::line_k, `USB_NEG_FILTER_CYCLES + 1 + len);
                roll(4, len);
                hold_line(usb_neg_pkg::line_j, `USB_NEG_FILTER_CYCLES + 1 + len);
            end
            wait_until(wait_done, `USB_NEG_HS_TIMEOUT + 20);
        end
        hold_line(usb_neg_pkg::line_j, 8);
    endtask

    initial begin
        int i;
        int j;
        int tmp;
        clk = 1'b0;
        rst_n = 1'b0;
        dp_in = 1'b1;
        dm_in = 1'b0;
        high_speed_supported = 1'b0;
        negotiation_enable = 1'b0;
        exp_speed = usb_neg_pkg::speed_full;
        k_forbidden = 1'b0;
        timeouts = 0;
        rng = 32'hca93_7fc3;
        kinds = '{0, 1, 2, 0, 1, 2, 1, 2};
        // shuffle the scenario order
        for (i = scenarios - 1; i > 0; i--) begin
            roll(i + 1, j);
            tmp = kinds[i];
            kinds[i] = kinds[j];
            kinds[j] = tmp;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        hold_line(usb_neg_pkg::line_j, 4);
        for (i = 0; i < scenarios; i++) begin
            run_scenario(kinds[i]);
        end
        $display("errors: %0d value, %0d rule, %0d timeout", value_errors, rule_errors, timeouts);
        if ((value_errors + rule_errors + timeouts) == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/usb_neg_pkg.sv
src/usb_line_state_decode.sv
src/usb_speed_negotiation.sv
src/usb_line_driver.sv
src/usb_hs_negotiator.sv
tests/usb_neg_assert.sv
tests/usb_neg_checker.sv
tests/tb_usb_hs_negotiator.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_usb_hs_negotiator
SRCS := $(filter-out +%,$(shell cat tb.f)) src/usb_neg_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) tb.f
	verilator --binary --timing --assert -f tb.f --top-module tb_usb_hs_negotiator \
		-o Vtb_usb_hs_negotiator

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
